//--- logic/issue_pkg.sv
// issue stage shared definitions
// widths, typedefs, enums and opcode constants for the OoO issue stage
`default_nettype none

package issue_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] insn_t;
    // zero means no tag / ready
    typedef logic [3:0]  rob_tag_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  rs_sel_t;

    localparam int      NUM_RS  = 4;
    localparam rs_sel_t RS_NONE = 3'd4;
    localparam rs_sel_t RS_FULL = 3'd5;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_BUBBLE = 7'b0000000;

    typedef enum logic [3:0] {
        ADD, SUB, XOR, OR, AND, SLL, SRL, SRA,
        SLT, SLTU, MUL, MULH, DIV, REMU
    } alu_op_e;

    // branch kinds use funct3 directly, NB sits in an unused slot
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        NB   = 3'b010,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_type_e;

    typedef enum logic [1:0] {
        BRANCH = 2'b00,
        REG    = 2'b10,
        LOAD   = 2'b11
    } itype_e;

    typedef enum logic [1:0] {
        SRC1_REG, SRC1_PC, SRC1_ZERO
    } src1_sel_e;

    typedef enum logic [0:0] {
        S_EMPTY = 1'b0,
        S_HOLD  = 1'b1
    } hold_state_e;

endpackage

`default_nettype wire

//--- logic/decode_if.sv
// decoded instruction fields
// carries decoder results to the reservation-station/ROB packet builder
`timescale 1ns/1ps
`default_nettype none

interface decode_if import issue_pkg::*; ();
    alu_op_e      alu_op;
    branch_type_e branch_type;
    logic         writes_rd;
    logic         is_load;
    logic         illegal;
    word_t        imm;
    logic         use_imm;
    src1_sel_e    src1_sel;
    itype_e       rob_itype;

    modport source (output alu_op, branch_type, writes_rd, is_load, illegal,
                    imm, use_imm, src1_sel, rob_itype);
    modport sink   (input  alu_op, branch_type, writes_rd, is_load, illegal,
                    imm, use_imm, src1_sel, rob_itype);
endinterface

`default_nettype wire

//--- logic/issue_ctrl.sv
// issue control
// holds a stalled instruction until a station and ROB slot free up,
// picks the lowest free reservation station and raises stall
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl import issue_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire insn_t             insn,
    input  wire word_t             pc,
    input  wire logic [NUM_RS-1:0] busy_bus,
    input  wire logic              rob_full,
    output insn_t                  cur_insn,
    output word_t                  cur_pc,
    output rs_sel_t                rs_dest,
    output logic                   stall,
    output logic                   pipe_hold
);
    hold_state_e state;
    hold_state_e state_next;
    insn_t       insn_hold;
    word_t       pc_hold;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_EMPTY;
            insn_hold <= '0;
            pc_hold   <= '0;
        end else begin
            state <= state_next;
            // capture only on the way into hold
            if (state == S_EMPTY && stall) begin
                insn_hold <= insn;
                pc_hold   <= pc;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_EMPTY: if (stall) state_next = S_HOLD;
            S_HOLD:  if (!stall) state_next = S_EMPTY;
            default: state_next = S_EMPTY;
        endcase
    end

    assign pipe_hold = (state == S_HOLD);
    assign cur_insn  = pipe_hold ? insn_hold : insn;
    assign cur_pc    = pipe_hold ? pc_hold : pc;

    // lowest free station wins, bubbles get no station
    always_comb begin
        rs_dest = RS_FULL;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (!busy_bus[i]) rs_dest = rs_sel_t'(i);
        end
        if (cur_insn[6:0] == OP_BUBBLE) rs_dest = RS_NONE;
    end

    assign stall = (rs_dest == RS_FULL) || rob_full;

    hold_entry_after_stall: assert property (@(posedge clk) disable iff (reset)
        $rose(state == S_HOLD) |-> $past(stall));

    rs_dest_in_range: assert property (@(posedge clk) disable iff (reset)
        rs_dest <= RS_FULL);

endmodule

`default_nettype wire

//--- logic/instr_decode.sv
// instruction decoder
// turns opcode/funct fields into ALU op, branch type, immediate and
// operand source selection for the issue stage
`timescale 1ns/1ps
`default_nettype none

module instr_decode import issue_pkg::*; (
    input  wire insn_t cur_insn,
    decode_if.source   dec
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;

    assign opcode = cur_insn[6:0];
    assign funct3 = cur_insn[14:12];
    assign funct7 = cur_insn[31:25];
    assign rd     = cur_insn[11:7];

    always_comb begin
        dec.alu_op      = ADD;
        dec.branch_type = NB;
        dec.writes_rd   = 1'b0;
        dec.is_load     = 1'b0;
        dec.illegal     = 1'b0;
        dec.imm         = '0;
        dec.use_imm     = 1'b0;
        dec.src1_sel    = SRC1_REG;
        dec.rob_itype   = REG;

        case (opcode)
            OP_R: begin
                dec.writes_rd = (rd != '0);
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec.alu_op = ADD;
                    {7'b0100000, 3'b000}: dec.alu_op = SUB;
                    {7'b0000000, 3'b100}: dec.alu_op = XOR;
                    {7'b0000000, 3'b110}: dec.alu_op = OR;
                    {7'b0000000, 3'b111}: dec.alu_op = AND;
                    {7'b0000000, 3'b001}: dec.alu_op = SLL;
                    {7'b0000000, 3'b101}: dec.alu_op = SRL;
                    {7'b0100000, 3'b101}: dec.alu_op = SRA;
                    {7'b0000000, 3'b010}: dec.alu_op = SLT;
                    {7'b0000001, 3'b000}: dec.alu_op = MUL;
                    {7'b0000001, 3'b001}: dec.alu_op = MULH;
                    {7'b0000001, 3'b100}: dec.alu_op = DIV;
                    {7'b0000001, 3'b111}: dec.alu_op = REMU;
                    default:              dec.alu_op = SLTU;
                endcase
            end
            OP_IMM: begin
                dec.writes_rd = (rd != '0);
                dec.use_imm   = 1'b1;
                dec.imm       = {{20{cur_insn[31]}}, cur_insn[31:20]};
                case (funct3)
                    3'b000: dec.alu_op = ADD;
                    3'b100: dec.alu_op = XOR;
                    3'b110: dec.alu_op = OR;
                    3'b111: dec.alu_op = AND;
                    3'b010: dec.alu_op = SLT;
                    3'b011: dec.alu_op = SLTU;
                    3'b001: dec.alu_op = SLL;
                    default: dec.alu_op = cur_insn[30] ? SRA : SRL;
                endcase
                // shifts take the unsigned shamt
                if (funct3 == 3'b001 || funct3 == 3'b101) dec.imm = {27'b0, cur_insn[24:20]};
            end
            OP_LOAD: begin
                dec.writes_rd = (rd != '0);
                dec.is_load   = 1'b1;
                dec.use_imm   = 1'b1;
                dec.imm       = {{20{cur_insn[31]}}, cur_insn[31:20]};
                dec.rob_itype = LOAD;
            end
            OP_LUI, OP_AUIPC: begin
                dec.writes_rd = (rd != '0);
                dec.use_imm   = 1'b1;
                dec.imm       = {cur_insn[31:12], 12'b0};
                dec.src1_sel  = (opcode == OP_LUI) ? SRC1_ZERO : SRC1_PC;
            end
            OP_BRANCH: begin
                // compare by subtract, offset goes to the ROB
                dec.alu_op      = SUB;
                dec.branch_type = branch_type_e'(funct3);
                dec.rob_itype   = BRANCH;
                dec.imm = {{19{cur_insn[31]}}, cur_insn[31], cur_insn[7],
                           cur_insn[30:25], cur_insn[11:8], 1'b0};
                // funct3 010/011 are not branches
                if (funct3[2:1] == 2'b01) begin
                    dec.illegal     = 1'b1;
                    dec.branch_type = NB;
                end
            end
            default: begin
                // bubble or unsupported, send zero operands
                dec.illegal  = (opcode != OP_BUBBLE);
                dec.src1_sel = SRC1_ZERO;
                dec.use_imm  = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/operand_resolve.sv
// operand resolve
// finds one source operand on the CDB, in the register file or in the ROB,
// otherwise passes on the ROB tag it waits for
`timescale 1ns/1ps
`default_nettype none

module operand_resolve import issue_pkg::*; (
    input  wire rob_tag_t cdb_tag,
    input  wire word_t    cdb_result,
    input  wire logic     cdb_load_step1,
    input  wire logic     reg_busy,
    input  wire word_t    reg_data,
    input  wire logic     rob_ready,
    input  wire word_t    rob_data,
    input  wire rob_tag_t wait_tag,
    output word_t         value,
    output rob_tag_t      tag
);
    always_comb begin
        value = '0;
        tag   = wait_tag;
        // a result on the CDB this cycle is newest
        if (cdb_tag != '0 && cdb_tag == wait_tag && !cdb_load_step1) begin
            value = cdb_result;
            tag   = '0;
        end else if (!reg_busy) begin
            value = reg_data;
            tag   = '0;
        end else if (rob_ready) begin
            value = rob_data;
            tag   = '0;
        end
    end

    always_comb begin
        tag_needs_busy_reg: assert final (tag == '0 || reg_busy);
    end

endmodule

`default_nettype wire

//--- logic/packet_build.sv
// packet builder
// assembles the reservation-station entry and the reduced ROB entry,
// and gates the issue side effects while stalled
`timescale 1ns/1ps
`default_nettype none

module packet_build import issue_pkg::*; (
    decode_if.sink        dec,
    input  wire word_t    cur_pc,
    input  wire logic     stall,
    input  wire rob_tag_t rob_entry,
    input  wire word_t    src1_value,
    input  wire word_t    src2_value,
    input  wire rob_tag_t src1_tag,
    input  wire rob_tag_t src2_tag,
    input  wire reg_idx_t cur_rd,
    output word_t         rs_v_j,
    output word_t         rs_v_k,
    output rob_tag_t      rs_q_j,
    output rob_tag_t      rs_q_k,
    output alu_op_e       rs_alu_op,
    output branch_type_e  rs_branch_type,
    output logic          rs_load,
    output logic          rs_busy,
    output rob_tag_t      rs_rob_tag,
    output rob_tag_t      rob_tag,
    output itype_e        rob_itype,
    output reg_idx_t      rob_reg_dest,
    output word_t         rob_value,
    output logic          rob_illegal,
    output logic          issue_writes
);
    // source 1: register, pc or zero
    always_comb begin
        case (dec.src1_sel)
            SRC1_REG: begin
                rs_v_j = src1_value;
                rs_q_j = src1_tag;
            end
            SRC1_PC: begin
                rs_v_j = cur_pc;
                rs_q_j = '0;
            end
            default: begin
                rs_v_j = '0;
                rs_q_j = '0;
            end
        endcase
    end

    assign rs_v_k = dec.use_imm ? dec.imm : src2_value;
    assign rs_q_k = dec.use_imm ? '0 : src2_tag;

    assign rs_alu_op      = dec.alu_op;
    assign rs_branch_type = dec.branch_type;
    assign rs_load        = dec.is_load;

    // nothing leaves the stage while stalled
    assign rs_busy      = !stall;
    assign rs_rob_tag   = stall ? '0 : rob_entry;
    assign rob_tag      = stall ? '0 : rob_entry;
    assign issue_writes = dec.writes_rd && !stall;

    assign rob_itype    = dec.rob_itype;
    assign rob_reg_dest = dec.writes_rd ? cur_rd : '0;
    // branch offset rides in the value field
    assign rob_value    = (dec.rob_itype == BRANCH) ? dec.imm : '0;
    assign rob_illegal  = dec.illegal;

    always_comb begin
        no_busy_on_stall: assert final (!(rs_busy && stall));
    end

endmodule

`default_nettype wire

//--- logic/issue_top.sv
// issue stage top
// one instruction per cycle into a reservation station and the ROB
`timescale 1ns/1ps
`default_nettype none

module issue_top import issue_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire insn_t             insn,
    input  wire word_t             pc,
    input  wire logic [NUM_RS-1:0] busy_bus,
    input  wire rob_tag_t          rob_entry,
    input  wire logic              rob_full,
    input  wire word_t             rs1_data,
    input  wire word_t             rs2_data,
    input  wire logic              rs1_busy,
    input  wire logic              rs2_busy,
    input  wire rob_tag_t          q_j,
    input  wire rob_tag_t          q_k,
    input  wire logic              rs1_rob_ready,
    input  wire logic              rs2_rob_ready,
    input  wire word_t             rs1_rob_data,
    input  wire word_t             rs2_rob_data,
    input  wire rob_tag_t          cdb_tag,
    input  wire word_t             cdb_result,
    input  wire logic              cdb_load_step1,
    output rs_sel_t                rs_dest,
    output logic                   stall,
    output logic                   pipe_hold,
    output reg_idx_t               rs1,
    output reg_idx_t               rs2,
    output reg_idx_t               issue_dest,
    output logic                   issue_writes,
    output word_t                  rs_v_j,
    output word_t                  rs_v_k,
    output rob_tag_t               rs_q_j,
    output rob_tag_t               rs_q_k,
    output alu_op_e                rs_alu_op,
    output branch_type_e           rs_branch_type,
    output logic                   rs_load,
    output logic                   rs_busy,
    output rob_tag_t               rs_rob_tag,
    output rob_tag_t               rob_tag,
    output itype_e                 rob_itype,
    output reg_idx_t               rob_reg_dest,
    output word_t                  rob_value,
    output logic                   rob_illegal
);
    insn_t    cur_insn;
    word_t    cur_pc;
    word_t    src1_value;
    word_t    src2_value;
    rob_tag_t src1_tag;
    rob_tag_t src2_tag;

    decode_if dec_if ();

    // register file / regstat lookups
    assign rs1        = cur_insn[19:15];
    assign rs2        = cur_insn[24:20];
    assign issue_dest = cur_insn[11:7];

    issue_ctrl issue_ctrl_inst (
        .clk, .reset, .insn, .pc, .busy_bus, .rob_full,
        .cur_insn, .cur_pc, .rs_dest, .stall, .pipe_hold
    );

    instr_decode instr_decode_inst (.cur_insn, .dec(dec_if.source));

    operand_resolve src1_resolve_inst (
        .cdb_tag, .cdb_result, .cdb_load_step1,
        .reg_busy(rs1_busy), .reg_data(rs1_data),
        .rob_ready(rs1_rob_ready), .rob_data(rs1_rob_data),
        .wait_tag(q_j), .value(src1_value), .tag(src1_tag)
    );

    operand_resolve src2_resolve_inst (
        .cdb_tag, .cdb_result, .cdb_load_step1,
        .reg_busy(rs2_busy), .reg_data(rs2_data),
        .rob_ready(rs2_rob_ready), .rob_data(rs2_rob_data),
        .wait_tag(q_k), .value(src2_value), .tag(src2_tag)
    );

    packet_build packet_build_inst (
        .dec(dec_if.sink), .cur_pc, .stall, .rob_entry,
        .src1_value, .src2_value, .src1_tag, .src2_tag, .cur_rd(issue_dest),
        .rs_v_j, .rs_v_k, .rs_q_j, .rs_q_k, .rs_alu_op, .rs_branch_type,
        .rs_load, .rs_busy, .rs_rob_tag, .rob_tag, .rob_itype,
        .rob_reg_dest, .rob_value, .rob_illegal, .issue_writes
    );

endmodule

`default_nettype wire

//--- dv/issue_tb.sv
// issue stage testbench
// replays dv/issue_stim.txt one line per cycle and checks every packet output
`timescale 1ns/1ps
`default_nettype none

module issue_tb import issue_pkg::*; ();
    localparam int NUM_COLS = 35;

    logic              clk;
    logic              reset;
    insn_t             insn;
    word_t             pc;
    logic [NUM_RS-1:0] busy_bus;
    rob_tag_t          rob_entry, q_j, q_k, cdb_tag;
    logic              rob_full, rs1_busy, rs2_busy, rs1_rob_ready, rs2_rob_ready;
    word_t             rs1_data, rs2_data, rs1_rob_data, rs2_rob_data, cdb_result;
    logic              cdb_load_step1;

    rs_sel_t           rs_dest;
    logic              stall, pipe_hold, issue_writes, rs_load, rs_busy, rob_illegal;
    reg_idx_t          rs1, rs2, issue_dest, rob_reg_dest;
    word_t             rs_v_j, rs_v_k, rob_value;
    rob_tag_t          rs_q_j, rs_q_k, rs_rob_tag, rob_tag;
    alu_op_e           rs_alu_op;
    branch_type_e      rs_branch_type;
    itype_e            rob_itype;

    // expected values of the current line
    rs_sel_t           exp_dest;
    logic              exp_stall, exp_hold, exp_writes, exp_load, exp_busy, exp_illegal;
    word_t             exp_v_j, exp_v_k, exp_rob_value;
    rob_tag_t          exp_q_j, exp_q_k, exp_rob_tag;
    logic [3:0]        exp_alu;
    logic [2:0]        exp_branch;
    logic [1:0]        exp_itype;
    reg_idx_t          exp_reg_dest;

    // instruction the stage should be working on this line
    insn_t             exp_insn;
    // model of the hold register
    insn_t             held_insn;

    int vec_idx     = 0;
    int cycle_count = 0;
    int cycle_limit = 1000;

    issue_top issue_top_inst (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("STATUS: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Error: line %0d %s expected %h actual %h", vec_idx, name, exp, act);
        abort_run("output mismatch");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    task automatic check_tag(input string name, input rob_tag_t exp, input rob_tag_t act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    task automatic check_alu(input string name, input alu_op_e exp, input alu_op_e act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    task automatic check_rs_sel(input string name, input rs_sel_t exp, input rs_sel_t act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    task automatic check_branch(input string name, input branch_type_e exp,
                                input branch_type_e act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    task automatic check_itype(input string name, input itype_e exp, input itype_e act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    task automatic check_outputs();
        check_rs_sel("rs_dest", exp_dest, rs_dest);
        check_bit("stall", exp_stall, stall);
        check_bit("pipe_hold", exp_hold, pipe_hold);
        check_bit("issue_writes", exp_writes, issue_writes);
        check_reg("rs1", exp_insn[19:15], rs1);
        check_reg("rs2", exp_insn[24:20], rs2);
        check_reg("issue_dest", exp_insn[11:7], issue_dest);
        check_word("rs_v_j", exp_v_j, rs_v_j);
        check_word("rs_v_k", exp_v_k, rs_v_k);
        check_tag("rs_q_j", exp_q_j, rs_q_j);
        check_tag("rs_q_k", exp_q_k, rs_q_k);
        check_alu("rs_alu_op", alu_op_e'(exp_alu), rs_alu_op);
        check_branch("rs_branch_type", branch_type_e'(exp_branch), rs_branch_type);
        check_bit("rs_load", exp_load, rs_load);
        check_bit("rs_busy", exp_busy, rs_busy);
        check_tag("rs_rob_tag", exp_rob_tag, rs_rob_tag);
        check_tag("rob_tag", exp_rob_tag, rob_tag);
        check_itype("rob_itype", itype_e'(exp_itype), rob_itype);
        check_reg("rob_reg_dest", exp_reg_dest, rob_reg_dest);
        check_word("rob_value", exp_rob_value, rob_value);
        check_bit("rob_illegal", exp_illegal, rob_illegal);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            abort_run("timeout");
        end
    end

    initial begin
        logic [8*256-1:0] header;
        logic [31:0]      word;
        int               fd;
        int               got;
        int               word_count;
        int               num_vecs;

        reset          = 1'b1;
        insn           = '0;
        pc             = '0;
        busy_bus       = '0;
        rob_entry      = '0;
        rob_full       = 1'b0;
        rs1_data       = '0;
        rs2_data       = '0;
        rs1_busy       = 1'b0;
        rs2_busy       = 1'b0;
        q_j            = '0;
        q_k            = '0;
        rs1_rob_ready  = 1'b0;
        rs2_rob_ready  = 1'b0;
        rs1_rob_data   = '0;
        rs2_rob_data   = '0;
        cdb_tag        = '0;
        cdb_result     = '0;
        cdb_load_step1 = 1'b0;
        exp_insn       = '0;
        held_insn      = '0;

        // first pass counts the vectors
        word_count = 0;
        fd = $fopen("dv/issue_stim.txt", "r");
        if (fd == 0) abort_run("cannot open dv/issue_stim.txt");
        got = $fgets(header, fd);
        got = $fgets(header, fd);
        while ($fscanf(fd, "%h", word) == 1) word_count++;
        $fclose(fd);
        num_vecs = word_count / NUM_COLS;
        if (num_vecs == 0 || word_count % NUM_COLS != 0)
            abort_run("stimulus file has no vectors or a short line");
        cycle_limit = num_vecs + 20;

        fd = $fopen("dv/issue_stim.txt", "r");
        got = $fgets(header, fd);
        got = $fgets(header, fd);

        repeat (4) @(posedge clk);
        for (int i = 0; i < num_vecs; i++) begin
            #1;
            vec_idx = i + 1;
            reset   = 1'b0;
            got = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          insn, pc, busy_bus, rob_entry, rob_full, rs1_data, rs2_data,
                          rs1_busy, rs2_busy, q_j, q_k, rs1_rob_ready, rs2_rob_ready,
                          rs1_rob_data, rs2_rob_data, cdb_tag, cdb_result, cdb_load_step1);
            if (got != 18) abort_run("could not read the inputs of a stimulus line");
            got = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          exp_dest, exp_stall, exp_hold, exp_writes, exp_v_j, exp_v_k,
                          exp_q_j, exp_q_k, exp_alu, exp_branch, exp_load, exp_busy,
                          exp_rob_tag, exp_itype, exp_reg_dest, exp_rob_value, exp_illegal);
            if (got != 17) abort_run("could not read the expected values of a line");
            // while held, the stage works on the stalled instruction
            exp_insn = exp_hold ? held_insn : insn;
            // sample just before the next rising edge
            #2.5;
            check_outputs();
            // first stalled cycle loads the hold register
            if (exp_stall && !exp_hold) held_insn = insn;
            @(posedge clk);
        end
        $fclose(fd);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
logic/issue_pkg.sv
logic/decode_if.sv
logic/issue_ctrl.sv
logic/instr_decode.sv
logic/operand_resolve.sv
logic/packet_build.sv
logic/issue_top.sv
dv/issue_tb.sv

//--- dv/issue_stim.txt
# in: insn pc busy rob_entry rob_full rs1_d rs2_d rs1_bsy rs2_bsy q_j q_k rdy1 rdy2 rob_d1 rob_d2 cdb_tag cdb_res ld1
# exp: rs_dest stall hold writes v_j v_k q_j q_k alu br load busy rob_tag itype reg_dest rob_value illegal
002081b3 100 0 1 0 11 22 0 0 0 0 0 0 0 0 0 0 0  0 0 0 1 11 22 0 0 0 2 0 1 1 2 3 0 0
40208233 104 1 2 0 11 22 0 0 0 0 0 0 0 0 0 0 0  1 0 0 1 11 22 0 0 1 2 0 1 2 2 4 0 0
022082b3 108 3 3 0 11 22 0 0 0 0 0 0 0 0 0 0 0  2 0 0 1 11 22 0 0 a 2 0 1 3 2 5 0 0
02209333 10c 7 4 0 11 22 0 0 0 0 0 0 0 0 0 0 0  3 0 0 1 11 22 0 0 b 2 0 1 4 2 6 0 0
0220c3b3 110 5 5 0 11 22 0 0 0 0 0 0 0 0 0 0 0  1 0 0 1 11 22 0 0 c 2 0 1 5 2 7 0 0
0220f433 114 e 6 0 11 22 0 0 0 0 0 0 0 0 0 0 0  0 0 0 1 11 22 0 0 d 2 0 1 6 2 8 0 0
00000000 118 0 0 0 11 22 0 0 0 0 0 0 0 0 0 0 0  4 0 0 0 0 0 0 0 0 2 0 1 0 2 0 0 0
ffb08493 11c 0 7 0 11 22 0 0 0 0 0 0 0 0 0 0 0  0 0 0 1 11 fffffffb 0 0 0 2 0 1 7 2 9 0 0
4030d513 120 0 8 0 11 22 0 0 0 0 0 0 0 0 0 0 0  0 0 0 1 11 3 0 0 7 2 0 1 8 2 a 0 0
123455b7 124 0 9 0 11 22 1 1 3 4 0 0 0 0 0 0 0  0 0 0 1 0 12345000 0 0 0 2 0 1 9 2 b 0 0
00001617 200 0 a 0 11 22 1 0 3 0 0 0 0 0 0 0 0  0 0 0 1 200 1000 0 0 0 2 0 1 a 2 c 0 0
002081b3 204 0 b 0 11 22 1 1 5 6 1 1 55 66 5 99 0  0 0 0 1 99 66 0 0 0 2 0 1 b 2 3 0 0
002081b3 208 0 c 0 11 22 1 1 5 6 0 1 55 66 5 99 1  0 0 0 1 0 66 5 0 0 2 0 1 c 2 3 0 0
002081b3 20c 0 d 0 11 22 0 1 7 8 0 0 0 0 7 77 0  0 0 0 1 77 0 0 8 0 2 0 1 d 2 3 0 0
002081b3 300 f e 0 11 22 0 0 0 0 0 0 0 0 0 0 0  5 1 0 0 11 22 0 0 0 2 0 0 0 2 3 0 0
40208233 304 f e 0 11 22 0 0 0 0 0 0 0 0 0 0 0  5 1 1 0 11 22 0 0 0 2 0 0 0 2 3 0 0
40208233 304 7 e 0 11 22 0 0 0 0 0 0 0 0 0 0 0  3 0 1 1 11 22 0 0 0 2 0 1 e 2 3 0 0
40208233 304 0 f 0 11 22 0 0 0 0 0 0 0 0 0 0 0  0 0 0 1 11 22 0 0 1 2 0 1 f 2 4 0 0
fe209ce3 308 0 1 0 11 22 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 11 22 0 0 1 1 0 1 1 0 0 fffffff8 0
0080a683 30c 0 2 0 11 22 0 0 0 0 0 0 0 0 0 0 0  0 0 0 1 11 8 0 0 0 2 1 1 2 3 d 0 0
0020a223 310 0 3 0 11 22 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 2 0 1 3 2 0 0 1
00208033 314 0 4 0 11 22 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 11 22 0 0 0 2 0 1 4 2 0 0 0
